/* project.f */
+incdir+hw
+incdir+verif
hw/nnPkg.sv
hw/reluNeuron.sv
hw/classDecide.sv
hw/pairClassifier.sv
verif/pairClassifierTb.sv

/* Bender.yml */
package:
  name: pair_classifier

sources:
  - include_dirs:
      - hw
    files:
      - hw/nnPkg.sv
      - hw/reluNeuron.sv
      - hw/classDecide.sv
      - hw/pairClassifier.sv

  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/pairClassifierTb.sv

/* verif/nnTbLib.svh */
`ifndef NN_TB_LIB_SVH
`define NN_TB_LIB_SVH

// the feedback polynomial is x^32 + x^22 + x^2 + x + 1 and the new bit enters at the bottom.
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// reference score of one hidden neuron; act0 sits in the low bits of vec.
function automatic logic [`NN_DATA_WIDTH-1:0] neuronModel(
	input int                                   which,
	input logic [`NN_DATA_WIDTH*`NN_INPUTS-1:0] vec
);
	logic [`NN_DATA_WIDTH-1:0]   weights [`NN_INPUTS];
	logic [`NN_DATA_WIDTH-1:0]   bias;
	logic [2*`NN_DATA_WIDTH-1:0] product;
	logic [`NN_DATA_WIDTH-1:0]   sum;
	if (which == 0)
	begin
		weights = '{`HID0_W0, `HID0_W1, `HID0_W2, `HID0_W3, `HID0_W4,
			`HID0_W5, `HID0_W6, `HID0_W7, `HID0_W8, `HID0_W9};
		bias = `HID0_BIAS;
	end
	else
	begin
		weights = '{`HID1_W0, `HID1_W1, `HID1_W2, `HID1_W3, `HID1_W4,
			`HID1_W5, `HID1_W6, `HID1_W7, `HID1_W8, `HID1_W9};
		bias = `HID1_BIAS;
	end
	sum = bias;
	for (int i = 0; i < `NN_INPUTS; i++)
	begin
		product = vec[i*`NN_DATA_WIDTH +: `NN_DATA_WIDTH] * weights[i];
		sum = sum + product[`NN_DATA_WIDTH-1:0]; // the sum wraps modulo 2^16.
	end
	if (sum[`NN_DATA_WIDTH-1])
	begin
		return '0; // a negative sum is clamped.
	end
	return sum;
endfunction

// scores are non-negative here, so they compare as unsigned values.
function automatic logic expectedClassId(input logic [`NN_DATA_WIDTH-1:0] s0,
	input logic [`NN_DATA_WIDTH-1:0] s1);
	return (s1 > s0); // equal scores select class 0.
endfunction

function automatic logic [`NN_DATA_WIDTH-1:0] expectedClassScore(
	input logic [`NN_DATA_WIDTH-1:0] s0,
	input logic [`NN_DATA_WIDTH-1:0] s1
);
	if (s1 > s0)
	begin
		return s1;
	end
	return s0;
endfunction

function automatic logic expectedNoActivation(input logic [`NN_DATA_WIDTH-1:0] s0,
	input logic [`NN_DATA_WIDTH-1:0] s1);
	return (s0 == '0) && (s1 == '0);
endfunction

`endif

/* verif/pairClassifierTb.sv */
`default_nettype none

`include "nn_defs.svh"

module pairClassifierTb;

	import nnPkg::*;

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 16;
	localparam int DrainCycles = 6;
	localparam int NumTests = 6;
	localparam int BiasVectors = 4;
	localparam int RandomVectors = 300;
	localparam int ClampVectors = 6;
	localparam int DecideVectors = 4;
	localparam int MidStreamVectors = 20;
	localparam int TotalCycles = 2 * ResetCycles + BiasVectors + RandomVectors +
		ClampVectors + DecideVectors + 2 * MidStreamVectors + NumTests * DrainCycles;
	localparam int WatchdogLimit = TotalCycles * ClkPeriod * 3 / 2;
	localparam int InputBits = `NN_DATA_WIDTH * `NN_INPUTS;

	logic                 clk = 1'b0;
	logic                 reset = 1'b1;
	logic [InputBits-1:0] actBus = '0;
	logic [InputBits-1:0] capturedBus;
	activation_t          hidScore0;
	activation_t          hidScore1;
	classIdx_t            classId;
	activation_t          classScore;
	logic                 noActivation;
	logic [31:0]          lfsrState = 32'hab5b;
	logic [2:0]           resetHistory = '1;
	int                   edgeCount = 0;
	int                   failCount = 0;
	int                   testStartFails = 0;
	int                   testsPassed = 0;
	int                   testsFailed = 0;
	string                testName = "reset";
	logic                 hidGate;
	logic                 decGate;

	`include "nnTbLib.svh"

	always #(ClkPeriod / 2) clk = ~clk;

	pairClassifier u_pairClassifier (
		.clk          (clk),
		.reset        (reset),
		.act0         (actBus[0*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act1         (actBus[1*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act2         (actBus[2*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act3         (actBus[3*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act4         (actBus[4*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act5         (actBus[5*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act6         (actBus[6*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act7         (actBus[7*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act8         (actBus[8*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.act9         (actBus[9*`NN_DATA_WIDTH +: `NN_DATA_WIDTH]),
		.hidScore0    (hidScore0),
		.hidScore1    (hidScore1),
		.classId      (classId),
		.classScore   (classScore),
		.noActivation (noActivation)
	);

	assign capturedBus = reset ? '0 : actBus; // the input registers load zeros in reset.

	// bit k holds reset as it was k+1 edges ago.
	always @(posedge clk)
	begin
		resetHistory <= {resetHistory[1:0], reset};
		edgeCount <= edgeCount + 1;
	end

	assign hidGate = (edgeCount >= 5) && (resetHistory[1:0] == '0);
	assign decGate = (edgeCount >= 5) && (resetHistory[2:0] == '0);

	task automatic reportMismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("CHECK FAILED test %s: %s expected %h actual %h", testName, what,
			expected, actual);
		failCount++;
	endtask

	resetClears: assert property (@(posedge clk) (edgeCount >= 2 && resetHistory[0])
		|-> ({hidScore0, hidScore1, classId, classScore, noActivation} == '0))
		else reportMismatch("outputs in reset", 64'd0,
			$sampled({hidScore0, hidScore1, classId, classScore, noActivation}));

	hidden0Matches: assert property (@(posedge clk) hidGate
		|-> (hidScore0 == neuronModel(0, $past(capturedBus, 3))))
		else reportMismatch("hidScore0", neuronModel(0, $past(capturedBus, 3)),
			$sampled(hidScore0));

	hidden1Matches: assert property (@(posedge clk) hidGate
		|-> (hidScore1 == neuronModel(1, $past(capturedBus, 3))))
		else reportMismatch("hidScore1", neuronModel(1, $past(capturedBus, 3)),
			$sampled(hidScore1));

	classIdMatches: assert property (@(posedge clk) decGate
		|-> (classId == expectedClassId(neuronModel(0, $past(capturedBus, 4)),
			neuronModel(1, $past(capturedBus, 4)))))
		else reportMismatch("classId", expectedClassId(neuronModel(0, $past(capturedBus, 4)),
			neuronModel(1, $past(capturedBus, 4))), $sampled(classId));

	classScoreMatches: assert property (@(posedge clk) decGate
		|-> (classScore == expectedClassScore(neuronModel(0, $past(capturedBus, 4)),
			neuronModel(1, $past(capturedBus, 4)))))
		else reportMismatch("classScore",
			expectedClassScore(neuronModel(0, $past(capturedBus, 4)),
			neuronModel(1, $past(capturedBus, 4))), $sampled(classScore));

	noActivationMatches: assert property (@(posedge clk) decGate
		|-> (noActivation == expectedNoActivation(neuronModel(0, $past(capturedBus, 4)),
			neuronModel(1, $past(capturedBus, 4)))))
		else reportMismatch("noActivation",
			expectedNoActivation(neuronModel(0, $past(capturedBus, 4)),
			neuronModel(1, $past(capturedBus, 4))), $sampled(noActivation));

	// an all-zero vector leaves only the biases, and neuron 0's bias is negative.
	biasHidden: assert property (@(posedge clk) (hidGate && $past(capturedBus, 3) == '0)
		|-> (hidScore0 == '0 && hidScore1 == activation_t'(`HID1_BIAS)))
		else reportMismatch("bias-only hidden scores", {16'd0, activation_t'(`HID1_BIAS)},
			$sampled({hidScore0, hidScore1}));

	biasDecision: assert property (@(posedge clk) (decGate && $past(capturedBus, 4) == '0)
		|-> (classId == 1'b1 && classScore == activation_t'(`HID1_BIAS) && !noActivation))
		else reportMismatch("bias-only decision", {1'b1, activation_t'(`HID1_BIAS), 1'b0},
			$sampled({classId, classScore, noActivation}));

	task automatic randomVector(output logic [InputBits-1:0] vec);
		for (int i = 0; i < InputBits; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			vec[i] = lfsrState[0];
		end
	endtask

	function automatic logic [InputBits-1:0] singleInput(input int idx,
		input activation_t value);
		logic [InputBits-1:0] vec;
		vec = '0;
		vec[idx*`NN_DATA_WIDTH +: `NN_DATA_WIDTH] = value;
		return vec;
	endfunction

	task automatic applyVector(input logic [InputBits-1:0] vec);
		@(negedge clk);
		actBus = vec;
	endtask

	task automatic startTest(input string name);
		testName = name;
		testStartFails = failCount;
	endtask

	task automatic closeTest();
		repeat (DrainCycles) @(negedge clk); // let the last vectors reach every check.
		$display("test %s finished with %0d check failures", testName,
			failCount - testStartFails);
		if (failCount == testStartFails)
		begin
			testsPassed++;
		end
		else
		begin
			testsFailed++;
		end
	endtask

	task automatic streamRandomVectors(input int count);
		logic [InputBits-1:0] vec;
		for (int i = 0; i < count; i++)
		begin
			randomVector(vec);
			applyVector(vec);
		end
	endtask

	initial
	begin
		logic [InputBits-1:0] vec;

		startTest("reset");
		repeat (ResetCycles) @(negedge clk);
		reset = 1'b0;
		closeTest();

		startTest("bias only");
		repeat (BiasVectors) applyVector('0);
		closeTest();

		startTest("random stream");
		streamRandomVectors(RandomVectors); // vectors go back to back, so three are in flight.
		closeTest();

		startTest("relu clamp");
		applyVector(singleInput(7, 16'd64)); // neuron 0 goes negative.
		applyVector(singleInput(7, 16'h0100)); // neuron 0 wraps to a negative sum.
		applyVector(singleInput(3, 16'd64)); // neuron 1 goes negative.
		applyVector(singleInput(3, 16'd32));
		applyVector(singleInput(6, 16'd16)); // both neurons clamp.
		applyVector(singleInput(9, 16'd1));
		closeTest();

		startTest("decision rule");
		applyVector(singleInput(6, 16'd1)); // both scores clamp and the tie goes to class 0.
		applyVector('0);
		applyVector(singleInput(3, 16'd64));
		applyVector(singleInput(0, 16'd1));
		closeTest();

		startTest("mid-stream reset");
		streamRandomVectors(MidStreamVectors);
		for (int i = 0; i < ResetCycles; i++)
		begin
			randomVector(vec);
			applyVector(vec);
			reset = 1'b1;
		end
		@(negedge clk);
		reset = 1'b0;
		streamRandomVectors(MidStreamVectors);
		closeTest();

		$display("tests passed: %0d, tests failed: %0d, check failures: %0d",
			testsPassed, testsFailed, failCount);
		if (failCount == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial
	begin
		#(WatchdogLimit);
		$display("timeout: the tests did not finish within %0d time units", WatchdogLimit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/pairClassifier.sv */
`default_nettype none

`include "nn_defs.svh"

module pairClassifier (
	input  logic               clk,
	input  logic               reset,
	input  nnPkg::activation_t act0,
	input  nnPkg::activation_t act1,
	input  nnPkg::activation_t act2,
	input  nnPkg::activation_t act3,
	input  nnPkg::activation_t act4,
	input  nnPkg::activation_t act5,
	input  nnPkg::activation_t act6,
	input  nnPkg::activation_t act7,
	input  nnPkg::activation_t act8,
	input  nnPkg::activation_t act9,
	output nnPkg::activation_t hidScore0,
	output nnPkg::activation_t hidScore1,
	output nnPkg::classIdx_t   classId,
	output nnPkg::activation_t classScore,
	output logic               noActivation
);

	// both neurons see the same vector on the same edge.
	reluNeuron #(
		.W0   (`HID0_W0),
		.W1   (`HID0_W1),
		.W2   (`HID0_W2),
		.W3   (`HID0_W3),
		.W4   (`HID0_W4),
		.W5   (`HID0_W5),
		.W6   (`HID0_W6),
		.W7   (`HID0_W7),
		.W8   (`HID0_W8),
		.W9   (`HID0_W9),
		.BIAS (`HID0_BIAS)
	) hidden0 (
		.clk   (clk),
		.reset (reset),
		.act0  (act0),
		.act1  (act1),
		.act2  (act2),
		.act3  (act3),
		.act4  (act4),
		.act5  (act5),
		.act6  (act6),
		.act7  (act7),
		.act8  (act8),
		.act9  (act9),
		.score (hidScore0)
	);

	reluNeuron #(
		.W0   (`HID1_W0),
		.W1   (`HID1_W1),
		.W2   (`HID1_W2),
		.W3   (`HID1_W3),
		.W4   (`HID1_W4),
		.W5   (`HID1_W5),
		.W6   (`HID1_W6),
		.W7   (`HID1_W7),
		.W8   (`HID1_W8),
		.W9   (`HID1_W9),
		.BIAS (`HID1_BIAS)
	) hidden1 (
		.clk   (clk),
		.reset (reset),
		.act0  (act0),
		.act1  (act1),
		.act2  (act2),
		.act3  (act3),
		.act4  (act4),
		.act5  (act5),
		.act6  (act6),
		.act7  (act7),
		.act8  (act8),
		.act9  (act9),
		.score (hidScore1)
	);

	// the decision lags the hidden scores by one edge.
	classDecide decide (
		.clk          (clk),
		.reset        (reset),
		.score0       (hidScore0),
		.score1       (hidScore1),
		.classId      (classId),
		.classScore   (classScore),
		.noActivation (noActivation)
	);

endmodule

`default_nettype wire

/* hw/classDecide.sv */
`default_nettype none

module classDecide (
	input  logic               clk,
	input  logic               reset,
	input  nnPkg::activation_t score0,
	input  nnPkg::activation_t score1,
	output nnPkg::classIdx_t   classId,
	output nnPkg::activation_t classScore,
	output logic               noActivation
);

	import nnPkg::*;

	logic        oneWins;
	activation_t bestScore;
	logic        bothZero;

	// scores are past the ReLU, so an unsigned compare is correct.
	always_comb
	begin
		oneWins = (score1 > score0); // a tie goes to class 0.
		if (oneWins)
		begin
			bestScore = score1;
		end
		else
		begin
			bestScore = score0;
		end
		bothZero = (score0 == '0) && (score1 == '0);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classId      <= '0;
			classScore   <= '0;
			noActivation <= 1'b0;
		end
		else
		begin
			classId      <= classIdx_t'(oneWins);
			classScore   <= bestScore;
			noActivation <= bothZero;
		end
	end

endmodule

`default_nettype wire

/* hw/reluNeuron.sv */
`default_nettype none

`include "nn_defs.svh"

module reluNeuron #(
	parameter nnPkg::weight_t W0 = '0,
	parameter nnPkg::weight_t W1 = '0,
	parameter nnPkg::weight_t W2 = '0,
	parameter nnPkg::weight_t W3 = '0,
	parameter nnPkg::weight_t W4 = '0,
	parameter nnPkg::weight_t W5 = '0,
	parameter nnPkg::weight_t W6 = '0,
	parameter nnPkg::weight_t W7 = '0,
	parameter nnPkg::weight_t W8 = '0,
	parameter nnPkg::weight_t W9 = '0,
	parameter nnPkg::weight_t BIAS = '0
) (
	input  logic               clk,
	input  logic               reset,
	input  nnPkg::activation_t act0,
	input  nnPkg::activation_t act1,
	input  nnPkg::activation_t act2,
	input  nnPkg::activation_t act3,
	input  nnPkg::activation_t act4,
	input  nnPkg::activation_t act5,
	input  nnPkg::activation_t act6,
	input  nnPkg::activation_t act7,
	input  nnPkg::activation_t act8,
	input  nnPkg::activation_t act9,
	output nnPkg::activation_t score
);

	import nnPkg::*;

	localparam weight_t Weights [`NN_INPUTS] = '{
		W0,
		W1,
		W2,
		W3,
		W4,
		W5,
		W6,
		W7,
		W8,
		W9
	};

	activation_t actReg [`NN_INPUTS]; // captured inputs of stage 1.
	accum_t      products [`NN_INPUTS];
	accum_t      sumNext;
	accum_t      sumReg; // wrapped sum of stage 2.

	// each product keeps only its low bits, which are the same for signed
	// and unsigned operands.
	always_comb
	begin
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			products[i] = accum_t'(actReg[i] * Weights[i]);
		end
	end

	always_comb
	begin
		sumNext = accum_t'(BIAS);
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			sumNext = sumNext + products[i]; // wraps modulo 2^16.
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				actReg[i] <= '0;
			end
		end
		else
		begin
			actReg[0] <= act0;
			actReg[1] <= act1;
			actReg[2] <= act2;
			actReg[3] <= act3;
			actReg[4] <= act4;
			actReg[5] <= act5;
			actReg[6] <= act6;
			actReg[7] <= act7;
			actReg[8] <= act8;
			actReg[9] <= act9;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	// ReLU clamp on the registered sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			score <= '0;
		end
		else if (sumReg[`NN_DATA_WIDTH-1])
		begin
			score <= '0; // a negative sum gives no activation.
		end
		else
		begin
			score <= activation_t'(sumReg);
		end
	end

endmodule

`default_nettype wire

/* hw/nnPkg.sv */
`default_nettype none

`include "nn_defs.svh"

package nnPkg;

	// one activation or neuron score.
	// two's complement before the ReLU, non-negative after it.
	typedef logic [`NN_DATA_WIDTH-1:0] activation_t;

	// one weight or bias in two's complement.
	typedef logic [`NN_DATA_WIDTH-1:0] weight_t;

	// the bias-plus-products sum inside a neuron wraps modulo 2^16.
	typedef logic [`NN_DATA_WIDTH-1:0] accum_t;

	// index of the winning hidden neuron.
	typedef logic [0:0] classIdx_t;

endpackage

`default_nettype wire

/* hw/nn_defs.svh */
`ifndef NN_DEFS_SVH
`define NN_DEFS_SVH

// width of every activation, weight, bias and internal sum.
`define NN_DATA_WIDTH 16

// number of activations feeding each hidden neuron.
`define NN_INPUTS 10

// weights and bias of hidden neuron 0.
`define HID0_W0 (-16'sd141)
`define HID0_W1 (16'sd228)
`define HID0_W2 (16'sd541)
`define HID0_W3 (16'sd430)
`define HID0_W4 (16'sd564)
`define HID0_W5 (16'sd932)
`define HID0_W6 (-16'sd239)
`define HID0_W7 (-16'sd377)
`define HID0_W8 (16'sd629)
`define HID0_W9 (-16'sd226)

// the negative bias keeps neuron 0 silent for an all-zero input.
`define HID0_BIAS (-16'sd89)

// hidden neuron 1 has a second set of mixed-sign weights.
`define HID1_W0 (16'sd312)
`define HID1_W1 (-16'sd187)
`define HID1_W2 (16'sd95)
`define HID1_W3 (-16'sd420)
`define HID1_W4 (16'sd268)
`define HID1_W5 (16'sd143)
`define HID1_W6 (-16'sd356)
`define HID1_W7 (16'sd77)
`define HID1_W8 (16'sd505)
`define HID1_W9 (-16'sd64)

// a positive bias, so neuron 1 wins when no input is active.
`define HID1_BIAS (16'sd120)

`endif
